//--- Makefile
VERILATOR  ?= verilator
TOP        ?= mem_subsys_tb
FILELIST   ?= mem_subsys_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Errors found
PASS_MSG   ?= No errors
VFLAGS     ?= --timing --assert
RUN_ARGS   ?= +verilator+error+limit+100

SIM_BIN    = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/dmem_lane.sv
`timescale 1ns/1ps

module dmem_lane (
   input  logic                                  clk,
   input  logic                                  cs_n_i,     // Bank select, active low
   input  logic                                  wr_n_i,     // Write, active low
   input  logic                                  be_i,       // This lane takes the write
   input  logic [pcore_mem_pkg::DMEM_AWIDTH-1:0] addr_i,
   input  logic [7:0]                            wdata_i,
   output logic [7:0]                            rdata_o
);

   import pcore_mem_pkg::*;

   logic [7:0] mem [DMEM_DEPTH];

   logic       wr_en;

   assign wr_en = ~wr_n_i & be_i;

   // Read first, so a same-word write returns the old byte
   always_ff @(posedge clk) begin
      if (!cs_n_i) begin
         rdata_o <= mem[addr_i];
         if (wr_en) begin
            mem[addr_i] <= wdata_i;
         end
      end
   end

endmodule : dmem_lane

//--- hw/load_unit.sv
`timescale 1ns/1ps

module load_unit (
   input  pcore_mem_pkg::type_ld_ctx_s           ld_ctx_i,
   input  pcore_mem_pkg::type_signal_from_dmem_s dmem2mem_i,
   output pcore_mem_pkg::type_mem2wb_data_s      mem2wb_data_o,
   output pcore_mem_pkg::type_mem2wb_ctrl_s      mem2wb_ctrl_o
);

   import pcore_mem_pkg::*;

   type_dmem_word_u     rdata;
   type_mem2wb_data_s   mem2wb_data;
   type_mem2wb_ctrl_s   mem2wb_ctrl;

   logic [7:0]          ld_byte;
   logic [15:0]         ld_hword;
   logic [XLEN-1:0]     ld_data;
   logic                hw_upper;

   assign rdata    = dmem2mem_i.data_rd;
   assign hw_upper = ld_ctx_i.byte_off[1];

   // Lane view of the returned word
   assign ld_byte  = rdata.lanes[ld_ctx_i.byte_off];
   assign ld_hword = {rdata.lanes[{hw_upper, 1'b1}], rdata.lanes[{hw_upper, 1'b0}]};

   // Sign or zero extension by opcode
   always_comb begin
      case (ld_ctx_i.mem_ld_ops)
         MEM_LD_OPS_LB  : ld_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
         MEM_LD_OPS_LBU : ld_data = {{(XLEN-8){1'b0}}, ld_byte};
         MEM_LD_OPS_LH  : ld_data = {{(XLEN-16){ld_hword[15]}}, ld_hword};
         MEM_LD_OPS_LHU : ld_data = {{(XLEN-16){1'b0}}, ld_hword};
         MEM_LD_OPS_LW  : ld_data = rdata.word;
         default        : ld_data = '0;         // Not a load
      endcase
   end

   // Writeback record
   always_comb begin
      mem2wb_data.pc         = ld_ctx_i.pc;
      mem2wb_data.alu_result = ld_ctx_i.alu_result;
      mem2wb_data.dmem_rdata = ld_data;
      mem2wb_data.rd_addr    = ld_ctx_i.rd_addr;

      mem2wb_ctrl.rd_wb_sel  = ld_ctx_i.rd_wb_sel;
      mem2wb_ctrl.rd_wr_req  = ld_ctx_i.rd_wr_req;
   end

   assign mem2wb_data_o = mem2wb_data;
   assign mem2wb_ctrl_o = mem2wb_ctrl;

endmodule : load_unit

//--- hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
   input  logic                               clk,
   input  logic                               rst_n_i,

   // From execute
   input  pcore_mem_pkg::type_exe2mem_data_s   exe2mem_data_i,
   input  pcore_mem_pkg::type_exe2mem_ctrl_s   exe2mem_ctrl_i,

   // Toward the lane banks, same cycle
   output pcore_mem_pkg::type_signal_to_dmem_s mem2dmem_o,

   // Toward the load unit, one cycle later
   output pcore_mem_pkg::type_ld_ctx_s         ld_ctx_o
);

   import pcore_mem_pkg::*;

   type_signal_to_dmem_s   mem2dmem;
   type_ld_ctx_s           ld_ctx_d;
   type_ld_ctx_s           ld_ctx_q;

   logic                   st_req;
   logic                   ld_req;
   logic [1:0]             byte_off;
   logic                   hw_upper;

   assign st_req   = (exe2mem_ctrl_i.mem_st_ops != MEM_ST_OPS_NONE);
   assign ld_req   = (exe2mem_ctrl_i.mem_ld_ops != MEM_LD_OPS_NONE);
   assign byte_off = exe2mem_data_i.alu_result[1:0];
   assign hw_upper = byte_off[1];                  // Halfword in lanes 3:2

   // Request word, lanes not addressed stay zero
   always_comb begin
      mem2dmem.addr         = exe2mem_data_i.alu_result;
      mem2dmem.cs           = ~(st_req | ld_req);
      mem2dmem.wr           = ~st_req;
      mem2dmem.data_wr.word = '0;
      mem2dmem.mask         = '0;

      case (exe2mem_ctrl_i.mem_st_ops)
         MEM_ST_OPS_SB : begin
            mem2dmem.data_wr.lanes[byte_off] = exe2mem_data_i.rs2_data[7:0];
            mem2dmem.mask[byte_off]          = 1'b1;
         end
         MEM_ST_OPS_SH : begin
            // Low byte of rs2 always lands in the even lane
            mem2dmem.data_wr.lanes[{hw_upper, 1'b0}] = exe2mem_data_i.rs2_data[7:0];
            mem2dmem.data_wr.lanes[{hw_upper, 1'b1}] = exe2mem_data_i.rs2_data[15:8];
            mem2dmem.mask = hw_upper ? 4'b1100 : 4'b0011;
         end
         MEM_ST_OPS_SW : begin
            mem2dmem.data_wr.word = exe2mem_data_i.rs2_data;
            mem2dmem.mask         = '1;
         end
         default : begin
         end
      endcase
   end

   // Next load context
   always_comb begin
      ld_ctx_d.mem_ld_ops = exe2mem_ctrl_i.mem_ld_ops;
      ld_ctx_d.byte_off   = byte_off;
      ld_ctx_d.pc         = exe2mem_data_i.pc;
      ld_ctx_d.alu_result = exe2mem_data_i.alu_result;
      ld_ctx_d.rd_addr    = exe2mem_data_i.instr[11:7];   // rd field
      ld_ctx_d.rd_wb_sel  = exe2mem_ctrl_i.rd_wb_sel;
      ld_ctx_d.rd_wr_req  = exe2mem_ctrl_i.rd_wr_req;
   end

   // Lines up with the registered read of the banks
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ld_ctx_q <= '0;
      end else begin
         ld_ctx_q <= ld_ctx_d;
      end
   end

   assign mem2dmem_o = mem2dmem;
   assign ld_ctx_o   = ld_ctx_q;

endmodule : mem_stage

//--- hw/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
   input  logic                               clk,
   input  logic                               rst_n_i,

   // Execute to memory
   input  pcore_mem_pkg::type_exe2mem_data_s   exe2mem_data_i,
   input  pcore_mem_pkg::type_exe2mem_ctrl_s   exe2mem_ctrl_i,

   // Memory to writeback
   output pcore_mem_pkg::type_mem2wb_data_s    mem2wb_data_o,
   output pcore_mem_pkg::type_mem2wb_ctrl_s    mem2wb_ctrl_o
);

   import pcore_mem_pkg::*;

   type_signal_to_dmem_s      mem2dmem;
   type_signal_from_dmem_s    dmem2mem;
   type_ld_ctx_s              ld_ctx;

   wire [NUM_LANES-1:0][7:0]  lane_rdata;   // One byte per bank
   logic [DMEM_AWIDTH-1:0]    word_idx;

   assign word_idx               = mem2dmem.addr[DMEM_AWIDTH+1:2];
   assign dmem2mem.data_rd.lanes = lane_rdata;

   mem_stage mem_stage_i (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .exe2mem_data_i (exe2mem_data_i),
      .exe2mem_ctrl_i (exe2mem_ctrl_i),
      .mem2dmem_o     (mem2dmem),
      .ld_ctx_o       (ld_ctx)
   );

   // Byte-lane banks share select, write and index
   for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
      dmem_lane dmem_lane_i (
         .clk     (clk),
         .cs_n_i  (mem2dmem.cs),
         .wr_n_i  (mem2dmem.wr),
         .be_i    (mem2dmem.mask[k]),
         .addr_i  (word_idx),
         .wdata_i (mem2dmem.data_wr.lanes[k]),
         .rdata_o (lane_rdata[k])
      );
   end

   load_unit load_unit_i (
      .ld_ctx_i      (ld_ctx),
      .dmem2mem_i    (dmem2mem),
      .mem2wb_data_o (mem2wb_data_o),
      .mem2wb_ctrl_o (mem2wb_ctrl_o)
   );

endmodule : mem_subsys_top

//--- hw/pcore_mem_pkg.sv
package pcore_mem_pkg;

   localparam int XLEN        = 32;
   localparam int NUM_LANES   = 4;
   localparam int DMEM_DEPTH  = 256;               // Words per lane bank
   localparam int DMEM_AWIDTH = $clog2(DMEM_DEPTH);

   // Load size and extension
   typedef enum logic [2:0] {
      MEM_LD_OPS_NONE = 3'b000,
      MEM_LD_OPS_LB   = 3'b001,
      MEM_LD_OPS_LH   = 3'b010,
      MEM_LD_OPS_LW   = 3'b011,
      MEM_LD_OPS_LBU  = 3'b100,
      MEM_LD_OPS_LHU  = 3'b101
   } type_ld_ops_e;

   typedef enum logic [1:0] {
      MEM_ST_OPS_NONE = 2'b00,
      MEM_ST_OPS_SB   = 2'b01,
      MEM_ST_OPS_SH   = 2'b10,
      MEM_ST_OPS_SW   = 2'b11
   } type_st_ops_e;

   // Writeback source, only carried through here
   typedef enum logic [1:0] {
      RD_WB_ALU    = 2'b00,
      RD_WB_MEM    = 2'b01,
      RD_WB_PC_INC = 2'b10,
      RD_WB_CSR    = 2'b11
   } type_wb_sel_e;

   typedef struct packed {
      logic [XLEN-1:0]     pc;
      logic [XLEN-1:0]     instr;
      logic [XLEN-1:0]     alu_result;           // Effective address on loads and stores
      logic [XLEN-1:0]     rs2_data;
   } type_exe2mem_data_s;

   typedef struct packed {
      type_ld_ops_e        mem_ld_ops;
      type_st_ops_e        mem_st_ops;
      type_wb_sel_e        rd_wb_sel;
      logic                rd_wr_req;
   } type_exe2mem_ctrl_s;

   typedef struct packed {
      logic [XLEN-1:0]     pc;
      logic [XLEN-1:0]     alu_result;
      logic [XLEN-1:0]     dmem_rdata;
      logic [4:0]          rd_addr;
   } type_mem2wb_data_s;

   typedef struct packed {
      type_wb_sel_e        rd_wb_sel;
      logic                rd_wr_req;
   } type_mem2wb_ctrl_s;

   // Data word seen whole or as byte lanes, lane k is byte k
   typedef union packed {
      logic [XLEN-1:0]                word;
      logic [NUM_LANES-1:0][7:0]      lanes;
   } type_dmem_word_u;

   typedef struct packed {
      logic [XLEN-1:0]     addr;
      type_dmem_word_u     data_wr;
      logic [NUM_LANES-1:0] mask;
      logic                cs;                   // Active low
      logic                wr;                   // Active low
   } type_signal_to_dmem_s;

   typedef struct packed {
      type_dmem_word_u     data_rd;
   } type_signal_from_dmem_s;

   // What the load unit needs one cycle after the request
   typedef struct packed {
      type_ld_ops_e        mem_ld_ops;
      logic [1:0]          byte_off;
      logic [XLEN-1:0]     pc;
      logic [XLEN-1:0]     alu_result;
      logic [4:0]          rd_addr;
      type_wb_sel_e        rd_wb_sel;
      logic                rd_wr_req;
   } type_ld_ctx_s;

endpackage : pcore_mem_pkg

//--- mem_subsys_top.f
hw/pcore_mem_pkg.sv
hw/mem_stage.sv
hw/dmem_lane.sv
hw/load_unit.sv
hw/mem_subsys_top.sv
testbench/mem_subsys_assert.sv
testbench/mem_subsys_tb.sv

//--- testbench/mem_subsys_assert.sv
`timescale 1ns/1ps

module mem_subsys_assert (
   input logic                                clk,
   input logic                                rst_n_i,
   input pcore_mem_pkg::type_exe2mem_ctrl_s   exe2mem_ctrl_i,
   input pcore_mem_pkg::type_signal_to_dmem_s mem2dmem_i,
   input pcore_mem_pkg::type_mem2wb_ctrl_s    mem2wb_ctrl_i
);

   import pcore_mem_pkg::*;

   int unsigned fail_count = 0;
   logic        req;

   assign req = (exe2mem_ctrl_i.mem_ld_ops != MEM_LD_OPS_NONE) ||
                (exe2mem_ctrl_i.mem_st_ops != MEM_ST_OPS_NONE);

   // Lanes are enabled only by a write
   mask_needs_write : assert property (@(posedge clk) disable iff (!rst_n_i)
      (mem2dmem_i.mask != '0) |-> !mem2dmem_i.wr)
      else begin
         fail_count++;
         $error("Lane mask set while wr is high");
      end

   cs_matches_request : assert property (@(posedge clk) disable iff (!rst_n_i)
      (!mem2dmem_i.cs) == req)
      else begin
         fail_count++;
         $error("cs does not follow the load or store request");
      end

   half_mask : assert property (@(posedge clk) disable iff (!rst_n_i)
      (exe2mem_ctrl_i.mem_st_ops == MEM_ST_OPS_SH) |-> (mem2dmem_i.mask inside {4'b0011, 4'b1100}))
      else begin
         fail_count++;
         $error("Halfword store with a bad lane mask");
      end

   // Context comes out of reset cleared
   quiet_after_reset : assert property (@(posedge clk)
      $rose(rst_n_i) |-> !mem2wb_ctrl_i.rd_wr_req)
      else begin
         fail_count++;
         $error("rd_wr_req high in the first cycle after reset");
      end

endmodule : mem_subsys_assert

bind mem_subsys_top mem_subsys_assert mem_subsys_assert_i (
   .clk            (clk),
   .rst_n_i        (rst_n_i),
   .exe2mem_ctrl_i (exe2mem_ctrl_i),
   .mem2dmem_i     (mem2dmem),
   .mem2wb_ctrl_i  (mem2wb_ctrl_o)
);

//--- testbench/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

   import pcore_mem_pkg::*;

   localparam int RESET_CYCLES    = 3;
   localparam int DIRECTED_CYCLES = 56;      // Steps of the five directed tests
   localparam int STREAM_WORDS    = 16;
   localparam int STREAM_LEN      = 200;
   localparam int STREAM_CYCLES   = STREAM_WORDS + STREAM_LEN + 1;
   localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + STREAM_CYCLES + 50;
   localparam logic [XLEN-1:0] STREAM_BASE = 32'h0000_0100;

   logic               clk;
   logic               rst_n_i;
   type_exe2mem_data_s exe2mem_data;
   type_exe2mem_ctrl_s exe2mem_ctrl;
   type_mem2wb_data_s  mem2wb_data;
   type_mem2wb_ctrl_s  mem2wb_ctrl;

   logic [7:0]         ref_mem [DMEM_DEPTH*NUM_LANES];   // Byte-addressed model
   type_mem2wb_data_s  exp_data;
   type_mem2wb_ctrl_s  exp_ctrl;
   logic               pend_valid;                       // Record waiting for its check
   int                 err_count;
   int unsigned        assert_errs;
   int                 cycle_count;
   int                 step_count;
   integer             seed;

   mem_subsys_top mem_subsys_top_i (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .exe2mem_data_i (exe2mem_data),
      .exe2mem_ctrl_i (exe2mem_ctrl),
      .mem2wb_data_o  (mem2wb_data),
      .mem2wb_ctrl_o  (mem2wb_ctrl)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Errors found");
         $finish;
      end
   end

   task automatic check_wb_data(input type_mem2wb_data_s exp, input type_mem2wb_data_s act);
      if (act.pc !== exp.pc) begin
         $display("Fail mem2wb_data_o.pc step %0d: expected %h, got %h",
                  step_count, exp.pc, act.pc);
         err_count++;
      end
      if (act.alu_result !== exp.alu_result) begin
         $display("Fail mem2wb_data_o.alu_result step %0d: expected %h, got %h",
                  step_count, exp.alu_result, act.alu_result);
         err_count++;
      end
      if (act.dmem_rdata !== exp.dmem_rdata) begin
         $display("Fail mem2wb_data_o.dmem_rdata step %0d: expected %h, got %h",
                  step_count, exp.dmem_rdata, act.dmem_rdata);
         err_count++;
      end
      if (act.rd_addr !== exp.rd_addr) begin
         $display("Fail mem2wb_data_o.rd_addr step %0d: expected %h, got %h",
                  step_count, exp.rd_addr, act.rd_addr);
         err_count++;
      end
   endtask

   task automatic check_wb_ctrl(input type_mem2wb_ctrl_s exp, input type_mem2wb_ctrl_s act);
      if (act.rd_wb_sel !== exp.rd_wb_sel) begin
         $display("Fail mem2wb_ctrl_o.rd_wb_sel step %0d: expected %h, got %h",
                  step_count, exp.rd_wb_sel, act.rd_wb_sel);
         err_count++;
      end
      if (act.rd_wr_req !== exp.rd_wr_req) begin
         $display("Fail mem2wb_ctrl_o.rd_wr_req step %0d: expected %h, got %h",
                  step_count, exp.rd_wr_req, act.rd_wr_req);
         err_count++;
      end
   endtask

   // Loaded value from the model with arithmetic extension
   function automatic logic [XLEN-1:0] model_load(input type_ld_ops_e op, input logic [9:0] a);
      logic [7:0]      b;
      logic [15:0]     h;
      logic [XLEN-1:0] result;
      b = ref_mem[a];
      h = {ref_mem[{a[9:1], 1'b1}], ref_mem[{a[9:1], 1'b0}]};
      case (op)
         MEM_LD_OPS_LB  : result = b[7] ? {24'h0, b} - 32'd256 : {24'h0, b};
         MEM_LD_OPS_LBU : result = {24'h0, b};
         MEM_LD_OPS_LH  : result = h[15] ? {16'h0, h} - 32'h0001_0000 : {16'h0, h};
         MEM_LD_OPS_LHU : result = {16'h0, h};
         MEM_LD_OPS_LW  : result = {ref_mem[{a[9:2], 2'd3}], ref_mem[{a[9:2], 2'd2}],
                                    ref_mem[{a[9:2], 2'd1}], ref_mem[{a[9:2], 2'd0}]};
         default        : result = '0;
      endcase
      return result;
   endfunction

   task automatic model_store(input type_st_ops_e op, input logic [9:0] a,
                              input logic [XLEN-1:0] wdata);
      case (op)
         MEM_ST_OPS_SB : ref_mem[a] = wdata[7:0];
         MEM_ST_OPS_SH : begin
            ref_mem[{a[9:1], 1'b0}] = wdata[7:0];
            ref_mem[{a[9:1], 1'b1}] = wdata[15:8];
         end
         MEM_ST_OPS_SW : begin
            for (int k = 0; k < NUM_LANES; k++) begin
               ref_mem[{a[9:2], 2'(k)}] = wdata[8*k +: 8];
            end
         end
         default : begin
         end
      endcase
   endtask

   task automatic check_pending();
      if (pend_valid) begin
         check_wb_data(exp_data, mem2wb_data);
         check_wb_ctrl(exp_ctrl, mem2wb_ctrl);
      end
   endtask

   // Checks the previous record and then drives the next one on the falling edge
   task automatic issue(input type_ld_ops_e ld, input type_st_ops_e st,
                        input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                        input logic [4:0] rd);
      type_exe2mem_data_s d;
      type_exe2mem_ctrl_s c;
      @(negedge clk);
      check_pending();
      step_count++;
      d.pc         = 32'h0000_1000 + (step_count << 2);
      d.instr      = {12'h5a3, 5'd9, 3'b010, rd, 7'b0000011};
      d.alu_result = addr;
      d.rs2_data   = wdata;
      c.mem_ld_ops = ld;
      c.mem_st_ops = st;
      // Loads write back memory data while other records vary the carried controls
      c.rd_wb_sel  = (ld != MEM_LD_OPS_NONE) ? RD_WB_MEM : type_wb_sel_e'(step_count[1:0]);
      c.rd_wr_req  = (ld != MEM_LD_OPS_NONE) || step_count[2];
      exe2mem_data = d;
      exe2mem_ctrl = c;
      exp_data.pc         = d.pc;
      exp_data.alu_result = addr;
      exp_data.dmem_rdata = model_load(ld, addr[9:0]);   // Before this record's own store
      exp_data.rd_addr    = rd;
      exp_ctrl.rd_wb_sel  = c.rd_wb_sel;
      exp_ctrl.rd_wr_req  = c.rd_wr_req;
      pend_valid          = 1'b1;
      model_store(st, addr[9:0], wdata);
   endtask

   task automatic idle();
      issue(MEM_LD_OPS_NONE, MEM_ST_OPS_NONE, '0, '0, 5'd0);
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      check_wb_data('0, mem2wb_data);
      check_wb_ctrl('0, mem2wb_ctrl);
      repeat (3) idle();
   endtask

   task automatic test_word_access();
      logic [XLEN-1:0] addrs [4];
      logic [XLEN-1:0] words [4];
      addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_03fc, 32'h8000_0200};
      words = '{32'hdead_beef, 32'h0123_4567, 32'hffff_0000, 32'h8000_0001};
      for (int i = 0; i < 4; i++) begin
         issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SW, addrs[i], words[i], 5'd0);
      end
      for (int i = 0; i < 4; i++) begin
         issue(MEM_LD_OPS_LW, MEM_ST_OPS_NONE, addrs[i], '0, 5'(10 + i));
      end
      idle();
   endtask

   task automatic test_byte_store();
      issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SW, 32'h0000_0040, 32'h1122_3344, 5'd0);
      for (int off = 0; off < 4; off++) begin
         // Upper rs2 bytes must not reach memory
         issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SB, 32'h0000_0040 + 32'(off),
               {24'hffffff, 8'(160 + off)}, 5'd0);
         issue(MEM_LD_OPS_LW, MEM_ST_OPS_NONE, 32'h0000_0040, '0, 5'd3);
      end
      idle();
   endtask

   task automatic test_byte_load();
      issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SW, 32'h0000_0084, 32'h80f1_7f85, 5'd0);
      issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SW, 32'h0000_0088, 32'h017f_4c33, 5'd0);
      for (int w = 0; w < 2; w++) begin
         for (int off = 0; off < 4; off++) begin
            issue(MEM_LD_OPS_LB, MEM_ST_OPS_NONE, 32'h0000_0084 + 32'(4*w + off), '0, 5'd5);
            issue(MEM_LD_OPS_LBU, MEM_ST_OPS_NONE, 32'h0000_0084 + 32'(4*w + off), '0, 5'd6);
         end
      end
      idle();
   endtask

   task automatic test_halfword();
      logic [15:0] vals [2];
      vals = '{16'h8a5c, 16'h7e01};            // Top bit set and then clear
      issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SW, 32'h0000_00c0, '0, 5'd0);
      for (int v = 0; v < 2; v++) begin
         for (int h = 0; h < 2; h++) begin
            issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SH, 32'h0000_00c0 + 32'(2*h),
                  {16'hbeef, vals[v]}, 5'd0);
            issue(MEM_LD_OPS_LH, MEM_ST_OPS_NONE, 32'h0000_00c0 + 32'(2*h), '0, 5'd7);
            issue(MEM_LD_OPS_LHU, MEM_ST_OPS_NONE, 32'h0000_00c0 + 32'(2*h), '0, 5'd8);
         end
      end
      idle();
   endtask

   function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
      return {addr[7:0] ^ 8'h5a, ~addr[9:2], addr[9:2], addr[7:0] ^ 8'hc3};
   endfunction

   task automatic test_stream();
      logic [31:0]  sel;
      logic [31:0]  rnd_a;
      logic [31:0]  rnd_d;
      logic [5:0]   off;
      type_ld_ops_e ld;
      type_st_ops_e st;
      for (int w = 0; w < STREAM_WORDS; w++) begin
         issue(MEM_LD_OPS_NONE, MEM_ST_OPS_SW, STREAM_BASE + 32'(4*w),
               fill_word(STREAM_BASE + 32'(4*w)), 5'd0);
      end
      for (int i = 0; i < STREAM_LEN; i++) begin
         sel   = $random(seed);
         rnd_a = $random(seed);
         rnd_d = $random(seed);
         off   = rnd_a[5:0];
         ld    = MEM_LD_OPS_NONE;
         st    = MEM_ST_OPS_NONE;
         case (sel[2:0])
            3'd0 : st = MEM_ST_OPS_SB;
            3'd1 : st = MEM_ST_OPS_SH;
            3'd2 : st = MEM_ST_OPS_SW;
            3'd3 : ld = MEM_LD_OPS_LB;
            3'd4 : ld = MEM_LD_OPS_LH;
            3'd5 : ld = MEM_LD_OPS_LW;
            3'd6 : ld = MEM_LD_OPS_LBU;
            default : ld = MEM_LD_OPS_LHU;
         endcase
         if (st == MEM_ST_OPS_SH || ld == MEM_LD_OPS_LH || ld == MEM_LD_OPS_LHU) begin
            off[0] = 1'b0;
         end
         if (st == MEM_ST_OPS_SW || ld == MEM_LD_OPS_LW) begin
            off[1:0] = 2'b00;
         end
         issue(ld, st, STREAM_BASE + {26'h0, off}, rnd_d, rnd_a[15:11]);
      end
      idle();
   endtask

   initial begin
      seed         = 42;
      err_count    = 0;
      cycle_count  = 0;
      step_count   = 0;
      pend_valid   = 1'b0;
      rst_n_i      = 1'b0;
      exe2mem_data = '0;
      exe2mem_ctrl = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n_i = 1'b1;

      test_reset_state();
      test_word_access();
      test_byte_store();
      test_byte_load();
      test_halfword();
      test_stream();
      @(negedge clk);
      check_pending();                          // Last idle record
      pend_valid = 1'b0;

      assert_errs = mem_subsys_top_i.mem_subsys_assert_i.fail_count;
      $display("Checks done: %0d compare errors, %0d assertion errors", err_count, assert_errs);
      if (err_count == 0 && assert_errs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule : mem_subsys_tb
